//--- hdl/cache_controller.sv
// Cache controller for the data memory
// Accepts one request at a time, decides hit or miss, writes through on
// stores, fills the line on a load miss and holds the response until taken
`default_nettype none

module cache_controller
    import dmem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp,
    output logic     lookup,
    output logic     fill,
    output logic     update,
    output index_t   index,
    output offset_t  offset,
    output tag_t     fill_tag,
    output line_t    fill_line,
    input  logic     line_valid,
    input  tag_t     line_tag,
    input  line_t    line_data,
    output logic     ram_read,
    output logic     ram_write,
    output addr_t    ram_addr,
    input  line_t    ram_line,
    output size_t    acc_size,
    output addr_t    acc_addr,
    output word_t    acc_wdata,
    input  word_t    load_value
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_FILL,
        ST_RESPOND
    } state_t;

    state_t   state;
    mem_req_t req_q;
    mem_rsp_t rsp_q;
    logic     rsp_valid_q;
    logic     hit;
    tag_t     req_tag;
    index_t   req_index;
    line_t    sel_line;
    word_t    sel_word;

    assign req_tag   = req_q.addr[TAG_LSB +: $bits(tag_t)];
    assign req_index = req_q.addr[INDEX_LSB +: $bits(index_t)];
    assign offset    = req_q.addr[OFFSET_LSB +: $bits(offset_t)];

    assign hit = line_valid && (line_tag == req_tag);   // Valid in ST_LOOKUP only

    assign req_ready = (state == ST_IDLE);
    assign lookup    = (state == ST_IDLE) && req_valid;
    assign index     = (state == ST_IDLE) ? req.addr[INDEX_LSB +: $bits(index_t)] : req_index;

    // Store writes through, cache word only updated on a hit
    assign ram_write = (state == ST_LOOKUP) && req_q.we;
    assign update    = (state == ST_LOOKUP) && req_q.we && hit;
    assign ram_read  = (state == ST_LOOKUP) && !req_q.we && !hit;
    assign ram_addr  = req_q.we ? {req_q.addr[15:2], 2'b00} : {req_tag, req_index, 4'b0000};

    assign fill      = (state == ST_FILL);
    assign fill_tag  = req_tag;
    assign fill_line = ram_line;

    // Answer word comes from the fetched line during a fill
    assign sel_line = (state == ST_FILL) ? ram_line : line_data;
    assign sel_word = sel_line[{offset, 5'b00000} +: 32];

    // Lane logic sees store data on stores and the selected word on loads
    assign acc_size  = req_q.size;
    assign acc_addr  = req_q.addr;
    assign acc_wdata = req_q.we ? req_q.wdata : sel_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            rsp_valid_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: state <= (req_q.we || hit) ? ST_RESPOND : ST_FILL;
                ST_FILL:   state <= ST_RESPOND;
                ST_RESPOND: begin
                    // Response register is loaded a cycle before valid rises
                    if (!rsp_valid_q) begin
                        rsp_valid_q <= 1'b1;
                    end else if (rsp_ready) begin
                        rsp_valid_q <= 1'b0;
                        state       <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state == ST_LOOKUP) begin
            rsp_q.rdata <= req_q.we ? '0 : load_value;
            rsp_q.hit   <= hit;
        end else if (state == ST_FILL) begin
            rsp_q.rdata <= load_value;
            rsp_q.hit   <= 1'b0;                        // Always a miss here
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

endmodule

`default_nettype wire

//--- hdl/cache_store.sv
// Direct-mapped cache storage
// Valid bits, tags and four-word lines for 16 entries, with a registered
// lookup port, a whole-line fill and a byte-enabled word update
`default_nettype none

module cache_store
    import dmem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     lookup,
    input  logic     fill,
    input  logic     update,
    input  index_t   index,
    input  offset_t  offset,
    input  tag_t     fill_tag,
    input  line_t    fill_line,
    input  byte_en_t byte_en,
    input  word_t    wdata,
    output logic     line_valid,
    output tag_t     line_tag,
    output line_t    line_data
);

    logic [NUM_LINES-1:0] valid;
    tag_t                 tags  [NUM_LINES];
    line_t                lines [NUM_LINES];

    logic [6:0] word_lsb;   // Bit position of the addressed word in a line

    assign word_lsb = {offset, 5'b00000};

    // Valid bits, the only state that reset touches
    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            line_valid <= 1'b0;
        end else begin
            if (fill) begin
                valid[index] <= 1'b1;
            end
            if (lookup) begin
                line_valid <= valid[index];
            end
        end
    end

    // Tag array
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[index] <= fill_tag;
        end
        if (lookup) begin
            line_tag <= tags[index];
        end
    end

    // Line array, fill and update never share a cycle
    always_ff @(posedge clk) begin
        if (fill) begin
            lines[index] <= fill_line;
        end else if (update) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    lines[index][word_lsb + 7'(8*b) +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (lookup) begin
            line_data <= lines[index];
        end
    end

endmodule

`default_nettype wire

//--- hdl/data_memory.sv
// Data memory top level
// Direct-mapped write-through cache in front of a byte-addressed RAM,
// with valid/ready handshakes on the request and response sides
`default_nettype none

module data_memory
    import dmem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output mem_rsp_t rsp
);

    logic     lookup;
    logic     fill;
    logic     update;
    index_t   index;
    offset_t  offset;
    tag_t     fill_tag;
    line_t    fill_line;
    logic     line_valid;
    tag_t     line_tag;
    line_t    line_data;
    logic     ram_read;
    logic     ram_write;
    addr_t    ram_addr;
    line_t    ram_line;
    size_t    acc_size;
    addr_t    acc_addr;
    word_t    acc_wdata;
    byte_en_t byte_en;
    word_t    lane_wdata;
    word_t    load_value;

    cache_controller ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .lookup     (lookup),
        .fill       (fill),
        .update     (update),
        .index      (index),
        .offset     (offset),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .line_valid (line_valid),
        .line_tag   (line_tag),
        .line_data  (line_data),
        .ram_read   (ram_read),
        .ram_write  (ram_write),
        .ram_addr   (ram_addr),
        .ram_line   (ram_line),
        .acc_size   (acc_size),
        .acc_addr   (acc_addr),
        .acc_wdata  (acc_wdata),
        .load_value (load_value)
    );

    cache_store cache_i (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .fill       (fill),
        .update     (update),
        .index      (index),
        .offset     (offset),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .byte_en    (byte_en),
        .wdata      (lane_wdata),
        .line_valid (line_valid),
        .line_tag   (line_tag),
        .line_data  (line_data)
    );

    main_ram ram_i (
        .clk     (clk),
        .read    (ram_read),
        .write   (ram_write),
        .addr    (ram_addr),
        .byte_en (byte_en),
        .wdata   (lane_wdata),
        .line    (ram_line)
    );

    // Same operand drives the store and load sides of the lane logic
    lane_align lanes_i (
        .size       (acc_size),
        .addr       (acc_addr),
        .wdata      (acc_wdata),
        .word       (acc_wdata),
        .byte_en    (byte_en),
        .lane_wdata (lane_wdata),
        .load_value (load_value)
    );

endmodule

`default_nettype wire

//--- hdl/dmem_pkg.sv
// Data memory shared definitions
// Widths, address field positions, access size codes and handshake payloads
`default_nettype none

package dmem_pkg;

    // Widths with a meaning of their own
    typedef logic [15:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;     // Four words, word 0 in the low bits
    typedef logic [7:0]   tag_t;
    typedef logic [3:0]   index_t;
    typedef logic [1:0]   offset_t;
    typedef logic [3:0]   byte_en_t;
    typedef logic [1:0]   size_t;

    // Access size codes
    localparam size_t SIZE_WORD = 2'd0;
    localparam size_t SIZE_BYTE = 2'd1;
    localparam size_t SIZE_HALF = 2'd2;

    // Address split: tag | index | word offset | byte offset
    localparam int TAG_LSB    = 8;
    localparam int INDEX_LSB  = 4;
    localparam int OFFSET_LSB = 2;

    localparam int NUM_LINES = 16;
    localparam int RAM_BYTES = 65536;

    typedef struct packed {
        addr_t addr;
        logic  we;      // High for a store
        size_t size;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        word_t rdata;   // Zero for a store
        logic  hit;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hdl/lane_align.sv
// Byte lane logic for the data memory
// Places store data on its lanes with byte enables, and pulls a
// zero-extended byte or halfword out of a loaded word
`default_nettype none

module lane_align
    import dmem_pkg::*;
(
    input  size_t    size,
    input  addr_t    addr,
    input  word_t    wdata,
    input  word_t    word,
    output byte_en_t byte_en,
    output word_t    lane_wdata,
    output word_t    load_value
);

    logic [4:0] shift;

    assign shift = {addr[1:0], 3'b000};   // Bit position of the addressed byte

    always_comb begin
        byte_en    = 4'b0000;              // Unused size code writes nothing
        lane_wdata = wdata;
        load_value = word;
        case (size)
            SIZE_WORD: byte_en = 4'b1111;
            SIZE_BYTE: begin
                byte_en    = 4'b0001 << addr[1:0];
                lane_wdata = wdata << shift;
                load_value = {24'h000000, word[shift +: 8]};
            end
            SIZE_HALF: begin
                // Halfword lane chosen by addr[1], addr[0] ignored
                byte_en    = addr[1] ? 4'b1100 : 4'b0011;
                lane_wdata = addr[1] ? {wdata[15:0], 16'h0000} : {16'h0000, wdata[15:0]};
                load_value = {16'h0000, addr[1] ? word[31:16] : word[15:0]};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/main_ram.sv
// Main RAM of the data memory
// Byte array with a registered read of a whole four-word line and a
// byte-enabled write of one aligned word
`default_nettype none

module main_ram
    import dmem_pkg::*;
(
    input  logic     clk,
    input  logic     read,
    input  logic     write,
    input  addr_t    addr,
    input  byte_en_t byte_en,
    input  word_t    wdata,
    output line_t    line
);

    logic [7:0] mem [RAM_BYTES];

    logic [11:0] line_base;   // Line number, addr[15:4]
    logic [13:0] word_base;   // Word number, addr[15:2]

    assign line_base = addr[15:4];
    assign word_base = addr[15:2];

    // Simulation image starts cleared
    initial begin
        for (int i = 0; i < RAM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
    end

    // Word write, low address bits dropped
    always_ff @(posedge clk) begin
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[{word_base, 2'(b)}] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Line read, byte 0 of the line lands in bits 7:0
    always_ff @(posedge clk) begin
        if (read) begin
            for (int b = 0; b < 16; b++) begin
                line[8*b +: 8] <= mem[{line_base, 4'(b)}];
            end
        end
    end

endmodule

`default_nettype wire

//--- project.f
hdl/dmem_pkg.sv
hdl/lane_align.sv
hdl/main_ram.sv
hdl/cache_store.sv
hdl/cache_controller.sv
hdl/data_memory.sv
testbench/data_memory_checker.sv
testbench/data_memory_tb.sv

//--- run.sh
#!/bin/sh
# Compile the data memory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module data_memory_tb -o data_memory_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/data_memory_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
fi
exit $status

//--- testbench/data_memory_checker.sv
// Handshake checker for the data memory
// Bound to the top level, flags protocol breaks on the request and response sides
`default_nettype none

module data_memory_checker
    import dmem_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req_ready,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input mem_rsp_t rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    // Response held steady while the consumer stalls
    rsp_held: assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    ) else $error("rsp changed or dropped while rsp_ready was low");

    no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(req_ready && rsp_valid)     // Request side closed while a response is pending
    ) else $error("req_ready and rsp_valid high in the same cycle");

    rsp_quiet_after_reset: assert property (
        @(posedge clk) rst |=> !rsp_valid
    ) else $error("rsp_valid high in the cycle after reset");

endmodule

bind data_memory data_memory_checker checker_i (
    .clk       (clk),
    .rst       (rst),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

`default_nettype wire

//--- testbench/data_memory_tb.sv
// Testbench for the data memory
// Applies a table of loads and stores, checks data, hit flag and response
// timing, and runs the last entries under random response back-pressure
`default_nettype none

module data_memory_tb
    import dmem_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int   NUM_ACCESSES  = 30;
    localparam int   PRESSURE_FROM = 22;   // First entry with back-pressure
    localparam int   WAIT_LIMIT    = 20;   // Cycles before a handshake wait gives up
    localparam logic LOAD          = 1'b0;
    localparam logic STORE         = 1'b1;

    typedef struct packed {
        logic  we;
        size_t size;
        addr_t addr;
        word_t wdata;
        word_t exp_data;
        logic  exp_hit;
    } access_t;

    logic     clk;
    logic     rst;
    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    mem_rsp_t rsp;

    access_t accesses [NUM_ACCESSES];
    integer  seed;

    data_memory dut_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_data(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s read 0x%08h, expected 0x%08h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s hit %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("Fail at %0d ns: %s answered after %0d cycles, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    function automatic access_t entry(input logic we, input size_t size, input addr_t addr,
                                      input word_t wdata, input word_t exp_data,
                                      input logic exp_hit);
        access_t acc;
        acc.we       = we;
        acc.size     = size;
        acc.addr     = addr;
        acc.wdata    = wdata;
        acc.exp_data = exp_data;
        acc.exp_hit  = exp_hit;
        return acc;
    endfunction

    // Expected values follow from a zeroed RAM, write-through without allocate
    task automatic build_table();
        accesses[0]  = entry(LOAD,  SIZE_WORD, 16'h0100, 32'h0000_0000, 32'h0000_0000, 1'b0);
        accesses[1]  = entry(STORE, SIZE_WORD, 16'h0210, 32'hDEAD_BEEF, 32'h0000_0000, 1'b0);
        accesses[2]  = entry(STORE, SIZE_WORD, 16'h0218, 32'h1234_5678, 32'h0000_0000, 1'b0);
        accesses[3]  = entry(LOAD,  SIZE_WORD, 16'h0210, 32'h0000_0000, 32'hDEAD_BEEF, 1'b0);
        accesses[4]  = entry(LOAD,  SIZE_WORD, 16'h0218, 32'h0000_0000, 32'h1234_5678, 1'b1);
        accesses[5]  = entry(STORE, SIZE_WORD, 16'h0214, 32'hCAFE_F00D, 32'h0000_0000, 1'b1);
        accesses[6]  = entry(LOAD,  SIZE_WORD, 16'h0214, 32'h0000_0000, 32'hCAFE_F00D, 1'b1);
        accesses[7]  = entry(STORE, SIZE_BYTE, 16'h0211, 32'h1234_56A5, 32'h0000_0000, 1'b1);
        accesses[8]  = entry(STORE, SIZE_HALF, 16'h0212, 32'hABCD_1357, 32'h0000_0000, 1'b1);
        accesses[9]  = entry(LOAD,  SIZE_BYTE, 16'h0211, 32'h0000_0000, 32'h0000_00A5, 1'b1);
        accesses[10] = entry(LOAD,  SIZE_BYTE, 16'h0213, 32'h0000_0000, 32'h0000_0013, 1'b1);
        accesses[11] = entry(LOAD,  SIZE_HALF, 16'h0212, 32'h0000_0000, 32'h0000_1357, 1'b1);
        accesses[12] = entry(LOAD,  SIZE_HALF, 16'h0210, 32'h0000_0000, 32'h0000_A5EF, 1'b1);
        accesses[13] = entry(LOAD,  SIZE_WORD, 16'h0210, 32'h0000_0000, 32'h1357_A5EF, 1'b1);
        // Same index, other tag evicts line 1
        accesses[14] = entry(LOAD,  SIZE_WORD, 16'h0310, 32'h0000_0000, 32'h0000_0000, 1'b0);
        accesses[15] = entry(LOAD,  SIZE_WORD, 16'h0210, 32'h0000_0000, 32'h1357_A5EF, 1'b0);
        accesses[16] = entry(LOAD,  SIZE_WORD, 16'h0214, 32'h0000_0000, 32'hCAFE_F00D, 1'b1);
        accesses[17] = entry(STORE, SIZE_WORD, 16'h0318, 32'h0BAD_CAFE, 32'h0000_0000, 1'b0);
        accesses[18] = entry(LOAD,  SIZE_WORD, 16'h021C, 32'h0000_0000, 32'h0000_0000, 1'b1);
        accesses[19] = entry(LOAD,  SIZE_WORD, 16'h0318, 32'h0000_0000, 32'h0BAD_CAFE, 1'b0);
        accesses[20] = entry(STORE, SIZE_BYTE, 16'h0523, 32'h0000_009C, 32'h0000_0000, 1'b0);
        accesses[21] = entry(LOAD,  SIZE_WORD, 16'h0520, 32'h0000_0000, 32'h9C00_0000, 1'b0);
        // Back-pressure part
        accesses[22] = entry(LOAD,  SIZE_HALF, 16'h0522, 32'h0000_0000, 32'h0000_9C00, 1'b1);
        accesses[23] = entry(STORE, SIZE_WORD, 16'h0524, 32'h55AA_55AA, 32'h0000_0000, 1'b1);
        accesses[24] = entry(LOAD,  SIZE_WORD, 16'h0524, 32'h0000_0000, 32'h55AA_55AA, 1'b1);
        accesses[25] = entry(LOAD,  SIZE_WORD, 16'h0630, 32'h0000_0000, 32'h0000_0000, 1'b0);
        accesses[26] = entry(STORE, SIZE_HALF, 16'h0632, 32'h0000_BEEF, 32'h0000_0000, 1'b1);
        accesses[27] = entry(LOAD,  SIZE_WORD, 16'h0630, 32'h0000_0000, 32'hBEEF_0000, 1'b1);
        accesses[28] = entry(LOAD,  SIZE_WORD, 16'h0210, 32'h0000_0000, 32'h1357_A5EF, 1'b0);
        accesses[29] = entry(LOAD,  SIZE_BYTE, 16'h0633, 32'h0000_0000, 32'h0000_00BE, 1'b1);
    endtask

    // Entered just after a falling edge, leaves on one with the DUT idle again
    task automatic run_access(input access_t acc, input int hold, input int num);
        int    waited;
        int    latency;
        int    exp_latency;
        string tag;
        tag         = $sformatf("entry %0d", num);
        exp_latency = (acc.we || acc.exp_hit) ? 2 : 3;   // Store or hit 2, miss 3
        waited      = 0;
        while (!req_ready) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("Timed out waiting for req_ready before %s", tag));
            end
            @(negedge clk);
            waited++;
        end
        req_valid  = 1'b1;
        req.addr   = acc.addr;
        req.we     = acc.we;
        req.size   = acc.size;
        req.wdata  = acc.wdata;
        rsp_ready  = (hold == 0);
        @(negedge clk);                                  // Accepted on the edge just passed
        req_valid  = 1'b0;
        req        = '0;
        latency    = 0;                                  // Edges after the accepting one
        while (!rsp_valid) begin
            check_flag(req_ready, 1'b0, $sformatf("%s req_ready while busy", tag));
            if (latency == WAIT_LIMIT) begin
                abort_run($sformatf("Timed out waiting for rsp_valid on %s", tag));
            end
            @(negedge clk);
            latency++;
        end
        check_latency(latency, exp_latency, tag);
        check_data(rsp.rdata, acc.exp_data, tag);
        check_hit(rsp.hit, acc.exp_hit, tag);
        // Stalled response must not move
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            check_flag(rsp_valid, 1'b1, $sformatf("%s rsp_valid under back-pressure", tag));
            check_flag(req_ready, 1'b0, $sformatf("%s req_ready under back-pressure", tag));
            check_data(rsp.rdata, acc.exp_data, tag);
            check_hit(rsp.hit, acc.exp_hit, tag);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        check_flag(rsp_valid, 1'b0, $sformatf("%s rsp_valid after transfer", tag));
        check_flag(req_ready, 1'b1, $sformatf("%s req_ready after transfer", tag));
    endtask

    initial begin
        int hold;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        seed      = 19450;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
        for (int i = 0; i < NUM_ACCESSES; i++) begin
            hold = 0;
            if (i >= PRESSURE_FROM) begin
                hold = 1 + ($unsigned($random(seed)) % 5);   // Stall of 1 to 5 cycles
            end
            run_access(accesses[i], hold, i);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
